// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       := nn_tb
FLIST     := list.f
OBJ_DIR   := obj_dir

SIM  := $(OBJ_DIR)/V$(TOP)
SRCS := $(wildcard src/*.sv src/*.svh sim/*.sv)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -q "All checks passed"

clean:
	rm -rf $(OBJ_DIR)

// ==== list.f ====
+incdir+src
src/nn_pkg.sv
src/fx_mul.sv
src/dense_pipe.sv
src/param_ram.sv
src/mem_arbiter.sv
src/layer_sequencer.sv
src/axil_slave.sv
src/nn_top.sv
sim/nn_asserts.sv
sim/nn_tb.sv

// ==== sim/nn_asserts.sv ====
`timescale 1ns/1ps

module nn_asserts (
    input  logic        clk,
    input  logic        rst,
    input  logic        bvalid,
    input  logic        bready,
    input  logic        rvalid,
    input  logic        rready,
    input  logic [31:0] rdata,
    input  logic        in_valid,
    input  logic        out_valid,
    input  logic        h_req,
    input  logic        h_gnt,
    input  logic        s_req,
    input  logic        s_gnt
);

    int fail_cnt = 0;  // Assertion failures so far

    // AXI responses stay up until the host takes them
    a_bvalid_hold: assert property (@(posedge clk) disable iff (rst)
        bvalid && !bready |=> bvalid)
        else begin
            fail_cnt++;
            $error("bvalid dropped before bready");
        end

    a_rvalid_hold: assert property (@(posedge clk) disable iff (rst)
        rvalid && !rready |=> rvalid && $stable(rdata))
        else begin
            fail_cnt++;
            $error("rvalid or rdata changed before rready");
        end

    // Four register stages between in_valid and out_valid
    a_pipe_latency: assert property (@(posedge clk) disable iff (rst)
        out_valid == $past(in_valid, 4))
        else begin
            fail_cnt++;
            $error("out_valid is not in_valid delayed by 4 cycles");
        end

    // A refused requester wins the next cycle
    a_host_turn: assert property (@(posedge clk) disable iff (rst)
        h_req && !h_gnt |=> h_gnt)
        else begin
            fail_cnt++;
            $error("host request refused two cycles in a row");
        end

    a_seq_turn: assert property (@(posedge clk) disable iff (rst)
        s_req && !s_gnt |=> s_gnt)
        else begin
            fail_cnt++;
            $error("sequencer request refused two cycles in a row");
        end

endmodule

// ==== sim/nn_tb.sv ====
`timescale 1ns/1ps
`include "nn_macros.svh"

module nn_tb;
    import nn_pkg::*;

    localparam int N_ROWS      = 4;
    localparam int WATCHDOG_NS = N_ROWS * 2000 + 5000;
    localparam int BP_CYCLES   = 4;  // Ready held low this long
    localparam logic [1:0] OKAY   = 2'b00;
    localparam logic [1:0] SLVERR = 2'b10;
    localparam logic [31:0] LFSR_POLY = 32'hA300_0000;
    localparam fx_t W_POS  = 32'sh0064_0000;  // +100.0
    localparam fx_t W_NEG  = 32'shFF9C_0000;  // -100.0
    localparam fx_t SAT_HI = 32'sh7FFF_FFFF;
    localparam fx_t SAT_LO = 32'sh8000_0000;

    // Nine Q16.16 inputs x0 to x8 per run
    localparam fx_t TAB_X [N_ROWS][`N_IN] = '{
        '{32'sh0001_0000, 32'shFFFD_8000, 32'sh0000_4000, 32'sh0003_0000, 32'shFFFF_0000,
          32'sh0000_8000, 32'sh0002_0000, 32'shFFFF_4000, 32'sh0001_8000},
        '{32'sh000A_0000, 32'shFFF8_E000, 32'sh0000_0042, 32'sh0064_0000, 32'shFFCD_8000,
          32'sh000C_0000, 32'shFFFD_0000, 32'sh0000_0000, 32'sh0008_C000},
        '{32'sh7530_0000, 32'sh8AD0_0000, 32'sh7530_0000, 32'sh8AD0_0000, 32'sh7530_0000,
          32'sh8AD0_0000, 32'sh7530_0000, 32'sh8AD0_0000, 32'sh7530_0000},
        '{32'sh00C8_0000, 32'shFF6A_0000, 32'sh0000_8000, 32'sh0040_0000, 32'shFFFF_F000,
          32'sh03E8_0000, 32'shFC18_0000, 32'sh0007_8000, 32'shFFDE_C000}
    };
    // Biases b0 to b3
    localparam fx_t TAB_B [N_ROWS][`M_OUT] = '{
        '{32'sh0000_8000, 32'shFFFF_0000, 32'sh0002_0000, 32'sh0000_0000},
        '{32'shFFF6_0000, 32'sh0004_4000, 32'sh0000_0000, 32'sh0000_0001},
        '{32'sh0001_0000, 32'shFFFF_0000, 32'sh0000_0000, 32'sh0000_0000},
        '{32'sh0001_0000, 32'shFFFF_0000, 32'sh012C_0000, 32'shFFFF_FFFF}
    };
    localparam bit TAB_WR [N_ROWS] = '{1'b1, 1'b1, 1'b0, 1'b1};  // 0 forces weights to +-100
    localparam bit TAB_BP [N_ROWS] = '{1'b0, 1'b1, 1'b0, 1'b1};  // Back-pressure rows

    logic        clk;
    logic        rst;
    logic [31:0] awaddr;
    logic        awvalid;
    logic        awready;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        wvalid;
    logic        wready;
    logic [1:0]  bresp;
    logic        bvalid;
    logic        bready;
    logic [31:0] araddr;
    logic        arvalid;
    logic        arready;
    logic [31:0] rdata;
    logic [1:0]  rresp;
    logic        rvalid;
    logic        rready;

    logic [31:0] lfsr = 32'd26;
    int          n_checks = 0;
    int          n_errs = 0;
    int          err_mark = 0;

    nn_top i_dut (.*);

    bind nn_top nn_asserts i_asserts (
        .clk       (clk),
        .rst       (rst),
        .bvalid    (bvalid),
        .bready    (bready),
        .rvalid    (rvalid),
        .rready    (rready),
        .rdata     (rdata),
        .in_valid  (pipe_valid),
        .out_valid (pipe_out_valid),
        .h_req     (h_req),
        .h_gnt     (h_gnt),
        .s_req     (s_req),
        .s_gnt     (s_gnt)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired, the DUT stopped answering");
        $display("Checks failed");
        $finish;
    end

    task automatic check_fx(input string name, input fx_t got, input fx_t exp);
        n_checks++;
        if (got !== exp) begin
            n_errs++;
            $display("ERR t=%0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_resp(input string name, input logic [1:0] got, input logic [1:0] exp);
        n_checks++;
        if (got !== exp) begin
            n_errs++;
            $display("ERR t=%0t %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        n_checks++;
        if (got !== exp) begin
            n_errs++;
            $display("ERR t=%0t %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic report_test(input string name);
        int e;
        e = n_errs - err_mark;
        if (e == 0) $display("test %s: ok", name);
        else        $display("test %s: %0d errors", name, e);
        err_mark = n_errs;
    endtask

    // One step of a right-shift Galois LFSR
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ LFSR_POLY) : (s >> 1);
    endfunction

    task automatic rand_weight(output fx_t w);
        logic [19:0] bits;
        for (int i = 0; i < 20; i++) begin
            bits[i] = lfsr[0];
            lfsr    = lfsr_next(lfsr);
        end
        w = {{12{bits[19]}}, bits};  // Within +-8
    endtask

    function automatic fx_t clamp(input longint v);
        if (v > longint'(SAT_HI)) return SAT_HI;
        if (v < longint'(SAT_LO)) return SAT_LO;
        return v[31:0];
    endfunction

    function automatic fx_t ref_mul(input fx_t a, input fx_t b);
        longint p;
        p = longint'(a) * longint'(b);
        return clamp(p >>> `FX_FRAC);
    endfunction

    function automatic fx_t ref_add(input fx_t a, input fx_t b);
        return clamp(longint'(a) + longint'(b));
    endfunction

    // Pairs, then pairs of pairs, then product 8, then the bias
    function automatic fx_t ref_neuron(input fx_t x [`N_IN], input fx_t w [`M_OUT][`N_IN],
                                       input fx_t b, input int l);
        fx_t p  [`N_IN];
        fx_t s1 [4];
        fx_t s2 [2];
        for (int k = 0; k < `N_IN; k++) p[k] = ref_mul(x[k], w[l][k]);
        for (int i = 0; i < 4; i++) s1[i] = ref_add(p[2*i], p[2*i+1]);
        s2[0] = ref_add(s1[0], s1[1]);
        s2[1] = ref_add(s1[2], s1[3]);
        return ref_add(ref_add(ref_add(s2[0], s2[1]), p[8]), b);
    endfunction

    // Starts and returns 1 ns after a rising edge
    task automatic axi_write(input logic [31:0] addr, input logic [31:0] data,
                             input int hold, output logic [1:0] resp);
        awaddr  = addr;
        wdata   = data;
        wstrb   = 4'hF;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        bready  = (hold == 0);
        do @(negedge clk); while (!(awready && wready));
        @(posedge clk);
        #1;
        awvalid = 1'b0;
        wvalid  = 1'b0;
        do @(negedge clk); while (!bvalid);
        resp = bresp;
        repeat (hold) begin
            @(negedge clk);
            check_bit("bvalid held", bvalid, 1'b1);
            check_resp("bresp held", bresp, resp);
        end
        if (hold > 0) begin
            @(posedge clk);
            #1 bready = 1'b1;
        end
        @(posedge clk);  // Response taken here
        #1 bready = 1'b0;
    endtask

    task automatic axi_read(input logic [31:0] addr, input int hold,
                            output logic [31:0] data, output logic [1:0] resp);
        araddr  = addr;
        arvalid = 1'b1;
        rready  = (hold == 0);
        do @(negedge clk); while (!arready);
        @(posedge clk);
        #1 arvalid = 1'b0;
        do @(negedge clk); while (!rvalid);
        data = rdata;
        resp = rresp;
        repeat (hold) begin
            @(negedge clk);
            check_bit("rvalid held", rvalid, 1'b1);
            check_fx("rdata held", rdata, data);
        end
        if (hold > 0) begin
            @(posedge clk);
            #1 rready = 1'b1;
        end
        @(posedge clk);
        #1 rready = 1'b0;
    endtask

    task automatic run_row(input int r);
        fx_t         x [`N_IN];
        fx_t         w [`M_OUT][`N_IN];
        fx_t         exp_y [`M_OUT];
        logic [31:0] d;
        logic [31:0] stat;
        logic [1:0]  rs;
        int          hold;
        hold = TAB_BP[r] ? BP_CYCLES : 0;
        for (int k = 0; k < `N_IN; k++) x[k] = TAB_X[r][k];
        for (int l = 0; l < `M_OUT; l++) begin
            for (int k = 0; k < `N_IN; k++) begin
                if (TAB_WR[r]) rand_weight(w[l][k]);
                else w[l][k] = ((k % 2 == 0) == (l % 2 == 0)) ? W_POS : W_NEG;
            end
            exp_y[l] = ref_neuron(x, w, TAB_B[r][l], l);
        end
        for (int k = 0; k < `N_IN; k++) begin
            axi_write(4 * (`X_BASE + k), x[k], 0, rs);
            check_resp("bresp x", rs, OKAY);
        end
        for (int l = 0; l < `M_OUT; l++) begin
            for (int k = 0; k < `N_IN; k++) begin
                axi_write(4 * (`W_BASE + l * `N_IN + k), w[l][k], 0, rs);
                check_resp("bresp w", rs, OKAY);
            end
            axi_write(4 * (`B_BASE + l), TAB_B[r][l], 0, rs);
            check_resp("bresp b", rs, OKAY);
        end
        axi_write(`CTRL_ADDR, 32'd1, hold, rs);
        check_resp("bresp ctrl", rs, OKAY);
        if (TAB_BP[r]) begin
            // Host RAM reads racing the sequencer
            for (int k = 0; k < 3; k++) begin
                axi_read(4 * (`X_BASE + k), hold, d, rs);
                check_fx("ram x during run", d, x[k]);
            end
        end
        do axi_read(`STAT_ADDR, 0, stat, rs); while (!stat[1]);
        check_bit("busy with done", stat[0], 1'b0);
        for (int l = 0; l < `M_OUT; l++) begin
            axi_read(`RES_ADDR + 4 * l, hold, d, rs);
            check_resp("rresp result", rs, OKAY);
            check_fx($sformatf("result %0d", l), d, exp_y[l]);
            if (!TAB_WR[r]) check_fx("saturated result", d, (l % 2 == 0) ? SAT_HI : SAT_LO);
        end
    endtask

    initial begin
        logic [31:0] d;
        logic [1:0]  rs;
        logic [31:0] rb_addr [4];
        logic [31:0] rb_data [4];
        rb_addr = '{32'h00C, 32'h054, 32'h108, 32'h3FC};  // x3, w5, b2, last word
        rb_data = '{32'h1234_5678, 32'hFFFE_8001, 32'h8000_0000, 32'h7FFF_FFFF};
        rst     = 1'b1;
        awaddr  = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wstrb   = 4'hF;
        wvalid  = 1'b0;
        bready  = 1'b0;
        araddr  = '0;
        arvalid = 1'b0;
        rready  = 1'b0;
        repeat (3) @(posedge clk);
        #1 rst = 1'b0;

        axi_read(`STAT_ADDR, 0, d, rs);
        check_fx("status after reset", d, '0);
        check_resp("rresp status", rs, OKAY);
        for (int l = 0; l < `M_OUT; l++) begin
            axi_read(`RES_ADDR + 4 * l, 0, d, rs);
            check_fx($sformatf("result %0d after reset", l), d, '0);
            check_resp("rresp result", rs, OKAY);
        end
        report_test("reset");

        for (int i = 0; i < 4; i++) begin
            axi_write(rb_addr[i], rb_data[i], 0, rs);
            check_resp("bresp ram", rs, OKAY);
        end
        for (int i = 0; i < 4; i++) begin
            axi_read(rb_addr[i], 0, d, rs);
            check_fx("ram readback", d, rb_data[i]);
            check_resp("rresp ram", rs, OKAY);
        end
        axi_read(32'h800, 0, d, rs);
        check_resp("rresp unmapped", rs, SLVERR);
        axi_write(32'h800, 32'h1, 0, rs);
        check_resp("bresp unmapped", rs, SLVERR);
        report_test("readback");

        for (int r = 0; r < N_ROWS; r++) begin
            run_row(r);
            report_test($sformatf("row %0d", r));
        end

        if (i_dut.i_asserts.fail_cnt != 0) begin
            $display("%0d bound assertions failed", i_dut.i_asserts.fail_cnt);
            n_errs += i_dut.i_asserts.fail_cnt;
        end
        $display("%0d checks, %0d errors", n_checks, n_errs);
        if (n_errs == 0) $display("All checks passed");
        else             $display("Checks failed");
        $finish;
    end

endmodule

// ==== src/axil_slave.sv ====
`timescale 1ns/1ps
`include "nn_macros.svh"

module axil_slave (
    input  logic                clk,
    input  logic                rst,
    input  logic [31:0]         awaddr,
    input  logic                awvalid,
    output logic                awready,
    input  logic [31:0]         wdata,
    input  logic [3:0]          wstrb,
    input  logic                wvalid,
    output logic                wready,
    output logic [1:0]          bresp,
    output logic                bvalid,
    input  logic                bready,
    input  logic [31:0]         araddr,
    input  logic                arvalid,
    output logic                arready,
    output logic [31:0]         rdata,
    output logic [1:0]          rresp,
    output logic                rvalid,
    input  logic                rready,
    // Arbiter port
    output logic                mem_req,
    output logic                mem_we,
    output nn_pkg::ram_addr_t   mem_addr,
    output nn_pkg::fx_t         mem_wdata,
    input  logic                mem_gnt,
    input  logic                mem_rdata_valid,
    input  nn_pkg::fx_t         mem_rdata,
    // Sequencer
    output logic                start,
    input  logic                busy,
    input  logic                done,
    input  nn_pkg::fx_vec_out_t result
);
    import nn_pkg::*;

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    typedef enum logic [2:0] {S_IDLE, S_WMEM, S_RMEM, S_RDAT, S_BRESP, S_RRESP} state_t;

    state_t state;
    logic   wr_acc;
    logic   rd_acc;
    logic   full_strb;
    logic   aw_ram, aw_ctrl, aw_reg;
    logic   ar_ram, ar_ctrl, ar_stat, ar_res;

    // Writes win when both arrive together
    assign wr_acc  = (state == S_IDLE) && awvalid && wvalid;
    assign rd_acc  = (state == S_IDLE) && arvalid && !(awvalid && wvalid);
    assign awready = wr_acc;
    assign wready  = wr_acc;
    assign arready = rd_acc;

    assign full_strb = (wstrb == 4'hF);  // Partial strobes are dropped

    assign aw_ram  = awaddr < `CTRL_ADDR;
    assign aw_ctrl = awaddr == `CTRL_ADDR;
    assign aw_reg  = (awaddr == `STAT_ADDR) ||
                     (awaddr >= `RES_ADDR && awaddr < `RES_ADDR + 4 * `M_OUT);
    assign ar_ram  = araddr < `CTRL_ADDR;
    assign ar_ctrl = araddr == `CTRL_ADDR;
    assign ar_stat = araddr == `STAT_ADDR;
    assign ar_res  = araddr >= `RES_ADDR && araddr < `RES_ADDR + 4 * `M_OUT;

    assign bvalid  = (state == S_BRESP);
    assign rvalid  = (state == S_RRESP);
    assign mem_req = (state == S_WMEM) || (state == S_RMEM);
    assign mem_we  = (state == S_WMEM);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= S_IDLE;
            start <= 1'b0;
        end else begin
            start <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (wr_acc) begin
                        state <= (aw_ram && full_strb) ? S_WMEM : S_BRESP;
                        if (aw_ctrl && full_strb && wdata[0] && !busy) start <= 1'b1;
                    end else if (rd_acc) begin
                        state <= ar_ram ? S_RMEM : S_RRESP;
                    end
                end
                S_WMEM:  if (mem_gnt) state <= S_BRESP;
                S_RMEM:  if (mem_gnt) state <= S_RDAT;
                S_RDAT:  if (mem_rdata_valid) state <= S_RRESP;
                S_BRESP: if (bready) state <= S_IDLE;
                S_RRESP: if (rready) state <= S_IDLE;
                default: state <= S_IDLE;
            endcase
        end
    end

    // Address, data and response fields
    always_ff @(posedge clk) begin
        if (wr_acc) begin
            mem_addr  <= awaddr[2 +: $bits(ram_addr_t)];
            mem_wdata <= wdata;
            bresp     <= (aw_ram || aw_ctrl || aw_reg) ? RESP_OKAY : RESP_SLVERR;
        end
        if (rd_acc) begin
            mem_addr <= araddr[2 +: $bits(ram_addr_t)];
            rresp    <= (ar_ram || ar_ctrl || ar_stat || ar_res) ? RESP_OKAY : RESP_SLVERR;
            if (ar_stat)     rdata <= {30'b0, done, busy};
            else if (ar_res) rdata <= result[araddr[2 +: $clog2(`M_OUT)]];
            else             rdata <= '0;
        end
        if (state == S_RDAT && mem_rdata_valid) rdata <= mem_rdata;
    end

endmodule

// ==== src/dense_pipe.sv ====
`timescale 1ns/1ps
`include "nn_macros.svh"

module dense_pipe (
    input  logic                clk,
    input  logic                rst,
    input  logic                in_valid,
    input  nn_pkg::fx_vec_in_t  in_x,
    input  nn_pkg::fx_t         in_w [`M_OUT][`N_IN],
    input  nn_pkg::fx_vec_out_t in_b,
    output logic                out_valid,
    output nn_pkg::fx_vec_out_t out_y
);
    import nn_pkg::*;

    logic [3:0] vld_sr;  // One bit per stage

    // Stage 1, operand registers
    fx_t x_r [`N_IN];
    fx_t w_r [`M_OUT][`N_IN];
    fx_t b_r [`M_OUT];

    // Stage 2, products
    fx_t prod   [`M_OUT][`N_IN];
    fx_t prod_r [`M_OUT][`N_IN];
    fx_t b_p    [`M_OUT];

    // Stage 3, adder tree
    fx_t lvl1   [`M_OUT][4];
    fx_t lvl2   [`M_OUT][2];
    fx_t tree   [`M_OUT];
    fx_t tree_r [`M_OUT];
    fx_t b_t    [`M_OUT];

    // Stage 4, bias
    fx_t y_r [`M_OUT];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            vld_sr <= '0;
        end else begin
            vld_sr <= {vld_sr[2:0], in_valid};
        end
    end

    assign out_valid = vld_sr[3];

    for (genvar l = 0; l < `M_OUT; l++) begin : g_row
        for (genvar k = 0; k < `N_IN; k++) begin : g_col
            fx_mul i_mul (
                .a (x_r[k]),
                .b (w_r[l][k]),
                .y (prod[l][k])
            );
        end
    end

    // Fixed summation order, product 8 joins after the pairs
    always_comb begin
        for (int l = 0; l < `M_OUT; l++) begin
            for (int i = 0; i < 4; i++) begin
                lvl1[l][i] = fx_sat_add(prod_r[l][2*i], prod_r[l][2*i+1]);
            end
            lvl2[l][0] = fx_sat_add(lvl1[l][0], lvl1[l][1]);
            lvl2[l][1] = fx_sat_add(lvl1[l][2], lvl1[l][3]);
            tree[l]    = fx_sat_add(fx_sat_add(lvl2[l][0], lvl2[l][1]), prod_r[l][`N_IN-1]);
        end
    end

    always_ff @(posedge clk) begin
        x_r <= in_x;
        w_r <= in_w;
        b_r <= in_b;
        prod_r <= prod;
        b_p    <= b_r;  // Bias rides along with its vector
        tree_r <= tree;
        b_t    <= b_p;
        for (int l = 0; l < `M_OUT; l++) begin
            y_r[l] <= fx_sat_add(tree_r[l], b_t[l]);
        end
    end

    assign out_y = y_r;

endmodule

// ==== src/fx_mul.sv ====
`timescale 1ns/1ps
`include "nn_macros.svh"

module fx_mul (
    input  nn_pkg::fx_t a,
    input  nn_pkg::fx_t b,
    output nn_pkg::fx_t y
);
    import nn_pkg::*;

    logic signed [2*`FX_W-1:0] prod_full;
    logic signed [2*`FX_W-1:0] prod_shift;

    always_comb begin
        // Both operands sign-extended to 64 bits before the multiply
        prod_full  = a * b;
        prod_shift = prod_full >>> `FX_FRAC;  // Truncate toward minus infinity
    end

    assign y = fx_sat(prod_shift);

endmodule

// ==== src/layer_sequencer.sv ====
`timescale 1ns/1ps
`include "nn_macros.svh"

module layer_sequencer (
    input  logic                clk,
    input  logic                rst,
    input  logic                start,
    // RAM requests
    output logic                req,
    output nn_pkg::ram_addr_t   addr,
    input  logic                gnt,
    input  logic                rdata_valid,
    input  nn_pkg::fx_t         rdata,
    // Pipeline
    output logic                pipe_valid,
    output nn_pkg::fx_vec_in_t  pipe_x,
    output nn_pkg::fx_t         pipe_w [`M_OUT][`N_IN],
    output nn_pkg::fx_vec_out_t pipe_b,
    input  logic                pipe_out_valid,
    input  nn_pkg::fx_vec_out_t pipe_y,
    // Status
    output logic                busy,
    output logic                done,
    output nn_pkg::fx_vec_out_t result
);
    import nn_pkg::*;

    localparam int W_OFS = `N_IN;
    localparam int B_OFS = `N_IN + `N_IN * `M_OUT;
    localparam int N_OPS = B_OFS + `M_OUT;  // 49 reads per run
    localparam int CNT_W = $clog2(N_OPS + 1);

    typedef enum logic [1:0] {S_IDLE, S_FETCH, S_FIRE, S_WAIT} state_t;

    state_t           state;
    logic [CNT_W-1:0] iss_cnt;
    logic [CNT_W-1:0] rcv_cnt;
    fx_t              op_r [N_OPS];

    assign req        = (state == S_FETCH) && (iss_cnt < CNT_W'(N_OPS));
    assign pipe_valid = (state == S_FIRE);
    assign busy       = (state != S_IDLE);

    // Read index to RAM word address
    always_comb begin
        if (iss_cnt < CNT_W'(W_OFS)) begin
            addr = ram_addr_t'(`X_BASE + iss_cnt);
        end else if (iss_cnt < CNT_W'(B_OFS)) begin
            addr = ram_addr_t'(`W_BASE + iss_cnt - W_OFS);
        end else begin
            addr = ram_addr_t'(`B_BASE + iss_cnt - B_OFS);
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= S_IDLE;
            iss_cnt <= '0;
            rcv_cnt <= '0;
            done    <= 1'b0;
            result  <= '{default: '0};
        end else begin
            case (state)
                S_IDLE: if (start) begin
                    state   <= S_FETCH;
                    iss_cnt <= '0;
                    rcv_cnt <= '0;
                    done    <= 1'b0;
                end
                S_FETCH: begin
                    if (gnt) iss_cnt <= iss_cnt + 1'b1;
                    if (rdata_valid) begin
                        rcv_cnt <= rcv_cnt + 1'b1;
                        if (rcv_cnt == CNT_W'(N_OPS - 1)) state <= S_FIRE;
                    end
                end
                S_FIRE: state <= S_WAIT;
                S_WAIT: if (pipe_out_valid) begin
                    result <= pipe_y;
                    done   <= 1'b1;
                    state  <= S_IDLE;  // busy falls with the capture
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rdata_valid) op_r[rcv_cnt] <= rdata;
    end

    // Operand words fan out to the pipeline vectors
    always_comb begin
        for (int k = 0; k < `N_IN; k++) pipe_x[k] = op_r[k];
        for (int l = 0; l < `M_OUT; l++) begin
            for (int k = 0; k < `N_IN; k++) pipe_w[l][k] = op_r[W_OFS + l * `N_IN + k];
            pipe_b[l] = op_r[B_OFS + l];
        end
    end

endmodule

// ==== src/mem_arbiter.sv ====
`timescale 1ns/1ps

module mem_arbiter (
    input  logic              clk,
    input  logic              rst,
    // Host side
    input  logic              h_req,
    input  logic              h_we,
    input  nn_pkg::ram_addr_t h_addr,
    input  nn_pkg::fx_t       h_wdata,
    output logic              h_gnt,
    output logic              h_rdata_valid,
    output nn_pkg::fx_t       h_rdata,
    // Sequencer side
    input  logic              s_req,
    input  logic              s_we,
    input  nn_pkg::ram_addr_t s_addr,
    input  nn_pkg::fx_t       s_wdata,
    output logic              s_gnt,
    output logic              s_rdata_valid,
    output nn_pkg::fx_t       s_rdata,
    // RAM side
    output logic              ram_we,
    output nn_pkg::ram_addr_t ram_addr,
    output nn_pkg::fx_t       ram_wdata,
    input  nn_pkg::fx_t       ram_rdata
);
    logic s_first;  // Sequencer has priority on a tie
    logic h_rd_q;
    logic s_rd_q;

    assign h_gnt = h_req && (!s_req || !s_first);
    assign s_gnt = s_req && (!h_req || s_first);

    assign ram_we    = (h_gnt && h_we) || (s_gnt && s_we);
    assign ram_addr  = s_gnt ? s_addr : h_addr;
    assign ram_wdata = s_gnt ? s_wdata : h_wdata;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            s_first <= 1'b0;
            h_rd_q  <= 1'b0;
            s_rd_q  <= 1'b0;
        end else begin
            if (h_gnt) s_first <= 1'b1;  // Flip after every grant
            if (s_gnt) s_first <= 1'b0;
            h_rd_q <= h_gnt && !h_we;
            s_rd_q <= s_gnt && !s_we;
        end
    end

    // Read data returns to whoever was granted last cycle
    assign h_rdata_valid = h_rd_q;
    assign s_rdata_valid = s_rd_q;
    assign h_rdata       = ram_rdata;
    assign s_rdata       = ram_rdata;

endmodule

// ==== src/nn_macros.svh ====
`ifndef NN_MACROS_SVH
`define NN_MACROS_SVH

// Layer geometry
`define N_IN       9
`define M_OUT      4

// Q16.16 word format
`define FX_W       32
`define FX_FRAC    16

`define RAM_DEPTH  256

// Word offsets inside the parameter RAM
`define X_BASE     0
`define W_BASE     16
`define B_BASE     64

// Register byte addresses, RAM window is 0x000 to 0x3FF
`define CTRL_ADDR  32'h400
`define STAT_ADDR  32'h404
`define RES_ADDR   32'h410

`endif

// ==== src/nn_pkg.sv ====
`include "nn_macros.svh"

package nn_pkg;

    typedef logic signed [`FX_W-1:0] fx_t;
    typedef logic [$clog2(`RAM_DEPTH)-1:0] ram_addr_t;

    typedef fx_t fx_vec_in_t [`N_IN];
    typedef fx_t fx_vec_out_t [`M_OUT];

    localparam fx_t FX_MAX = {1'b0, {(`FX_W-1){1'b1}}};
    localparam fx_t FX_MIN = {1'b1, {(`FX_W-1){1'b0}}};

    // Clamp a double-width intermediate to one word
    function automatic fx_t fx_sat(input logic signed [2*`FX_W-1:0] v);
        if (v > FX_MAX) return FX_MAX;
        if (v < FX_MIN) return FX_MIN;
        return fx_t'(v[`FX_W-1:0]);
    endfunction

    // Add with one guard bit, clamp on overflow
    function automatic fx_t fx_sat_add(input fx_t a, input fx_t b);
        logic signed [`FX_W:0] sum;
        sum = a + b;
        if (sum > FX_MAX) return FX_MAX;
        if (sum < FX_MIN) return FX_MIN;
        return fx_t'(sum[`FX_W-1:0]);
    endfunction

endpackage

// ==== src/nn_top.sv ====
`timescale 1ns/1ps
`include "nn_macros.svh"

module nn_top (
    input  logic        clk,
    input  logic        rst,
    input  logic [31:0] awaddr,
    input  logic        awvalid,
    output logic        awready,
    input  logic [31:0] wdata,
    input  logic [3:0]  wstrb,
    input  logic        wvalid,
    output logic        wready,
    output logic [1:0]  bresp,
    output logic        bvalid,
    input  logic        bready,
    input  logic [31:0] araddr,
    input  logic        arvalid,
    output logic        arready,
    output logic [31:0] rdata,
    output logic [1:0]  rresp,
    output logic        rvalid,
    input  logic        rready
);
    import nn_pkg::*;

    // Host requests
    logic        h_req, h_we, h_gnt, h_rdata_valid;
    ram_addr_t   h_addr;
    fx_t         h_wdata, h_rdata;

    // Sequencer requests
    logic        s_req, s_gnt, s_rdata_valid;
    ram_addr_t   s_addr;
    fx_t         s_rdata;

    logic        ram_we;
    ram_addr_t   ram_addr;
    fx_t         ram_wdata, ram_rdata;

    logic        start, busy, done;
    fx_vec_out_t result;

    logic        pipe_valid, pipe_out_valid;
    fx_vec_in_t  pipe_x;
    fx_t         pipe_w [`M_OUT][`N_IN];
    fx_vec_out_t pipe_b, pipe_y;

    axil_slave i_axil_slave (
        .clk, .rst,
        .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
        .bresp, .bvalid, .bready, .araddr, .arvalid, .arready,
        .rdata, .rresp, .rvalid, .rready,
        .mem_req         (h_req),
        .mem_we          (h_we),
        .mem_addr        (h_addr),
        .mem_wdata       (h_wdata),
        .mem_gnt         (h_gnt),
        .mem_rdata_valid (h_rdata_valid),
        .mem_rdata       (h_rdata),
        .start, .busy, .done, .result
    );

    mem_arbiter i_mem_arbiter (
        .clk, .rst,
        .h_req, .h_we, .h_addr, .h_wdata, .h_gnt, .h_rdata_valid, .h_rdata,
        .s_req,
        .s_we    (1'b0),  // Sequencer only reads
        .s_addr,
        .s_wdata ('0),
        .s_gnt, .s_rdata_valid, .s_rdata,
        .ram_we, .ram_addr, .ram_wdata, .ram_rdata
    );

    param_ram i_param_ram (
        .clk,
        .we    (ram_we),
        .addr  (ram_addr),
        .wdata (ram_wdata),
        .rdata (ram_rdata)
    );

    layer_sequencer i_layer_sequencer (
        .clk, .rst, .start,
        .req         (s_req),
        .addr        (s_addr),
        .gnt         (s_gnt),
        .rdata_valid (s_rdata_valid),
        .rdata       (s_rdata),
        .pipe_valid, .pipe_x, .pipe_w, .pipe_b, .pipe_out_valid, .pipe_y,
        .busy, .done, .result
    );

    dense_pipe i_dense_pipe (
        .clk, .rst,
        .in_valid  (pipe_valid),
        .in_x      (pipe_x),
        .in_w      (pipe_w),
        .in_b      (pipe_b),
        .out_valid (pipe_out_valid),
        .out_y     (pipe_y)
    );

endmodule

// ==== src/param_ram.sv ====
`timescale 1ns/1ps
`include "nn_macros.svh"

module param_ram (
    input  logic              clk,
    input  logic              we,
    input  nn_pkg::ram_addr_t addr,
    input  nn_pkg::fx_t       wdata,
    output nn_pkg::fx_t       rdata
);
    import nn_pkg::*;

    fx_t mem [`RAM_DEPTH];

    // Read-first, data one cycle after the request
    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
        rdata <= mem[addr];
    end

endmodule
